/* Makefile */
# Verilator build and run for the data cache testbench
# any variable below can be set on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= dcache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -x "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* cache_array.sv */
module cache_array (
    input  logic                                                clock,
    input  logic                                                reset,
    input  dcache_pkg::cache_req_t                              request,
    input  dcache_pkg::fill_t                                   fill,
    output logic                                                hit,
    output logic                                                hit_accept,
    output dcache_pkg::load_resp_t                              hit_resp,
    output dcache_pkg::load_resp_t [dcache_pkg::QUEUE_DEPTH-1:0] fill_resp,
    output dcache_pkg::victim_t                                 victim
);

    logic [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-1:0] valid;
    logic [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-1:0] dirty;
    // way to replace next
    dcache_pkg::way_t [dcache_pkg::SETS-1:0] lru;
    dcache_pkg::tag_t   tags   [dcache_pkg::SETS][dcache_pkg::WAYS];
    dcache_pkg::block_t blocks [dcache_pkg::SETS][dcache_pkg::WAYS];

    dcache_pkg::tag_t            req_tag;
    dcache_pkg::index_t          req_index;
    logic                        req_word;
    logic [dcache_pkg::WAYS-1:0] way_hit;
    dcache_pkg::way_t            hit_way;
    dcache_pkg::way_t            fill_way;
    dcache_pkg::block_t          fill_block;
    logic                        fill_dirty;

    assign req_tag   = request.addr[31 -: dcache_pkg::TAG_BITS];
    assign req_index = request.addr[dcache_pkg::OFFSET_BITS +: dcache_pkg::INDEX_BITS];
    assign req_word  = request.addr[dcache_pkg::OFFSET_BITS-1];
    assign fill_way  = lru[fill.index];

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            way_hit[w] = valid[req_index][w] && tags[req_index][w] == req_tag;
            if (way_hit[w]) begin
                hit_way = dcache_pkg::way_t'(w);
            end
        end
    end

    assign hit = request.valid && |way_hit;
    // a refill owns its set for the cycle
    assign hit_accept = hit && !(fill.valid && fill.index == req_index);

    assign hit_resp = '{
        valid: hit_accept && !request.is_store,
        id:    request.id,
        data:  blocks[req_index][hit_way][req_word*dcache_pkg::WORD_BITS +: dcache_pkg::WORD_BITS]
    };

    // replay the merged requests in order over the new block
    always_comb begin
        fill_block = fill.block;
        fill_dirty = 1'b0;
        fill_resp  = '0;
        for (int i = 0; i < dcache_pkg::QUEUE_DEPTH; i++) begin
            if (fill.valid && fill.entry_valid[i]) begin
                if (fill.entries[i].is_store) begin
                    fill_block[fill.entries[i].word_sel*dcache_pkg::WORD_BITS
                               +: dcache_pkg::WORD_BITS] = fill.entries[i].data;
                    fill_dirty = 1'b1;
                end else begin
                    fill_resp[i].valid = 1'b1;
                    fill_resp[i].id    = fill.entries[i].id;
                    fill_resp[i].data  = fill_block[fill.entries[i].word_sel*dcache_pkg::WORD_BITS
                                                    +: dcache_pkg::WORD_BITS];
                end
            end
        end
    end

    assign victim = '{
        valid: fill.valid && valid[fill.index][fill_way] && dirty[fill.index][fill_way],
        addr:  {tags[fill.index][fill_way], fill.index, {dcache_pkg::OFFSET_BITS{1'b0}}},
        block: blocks[fill.index][fill_way]
    };

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
            lru   <= '0;
        end else begin
            if (fill.valid) begin
                valid[fill.index][fill_way] <= 1'b1;
                dirty[fill.index][fill_way] <= fill_dirty;
                lru[fill.index]             <= ~fill_way;
            end
            if (hit_accept) begin
                lru[req_index] <= ~hit_way;
                if (request.is_store) begin
                    dirty[req_index][hit_way] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fill.valid) begin
            tags[fill.index][fill_way]   <= fill.tag;
            blocks[fill.index][fill_way] <= fill_block;
        end
        if (hit_accept && request.is_store) begin
            blocks[req_index][hit_way][req_word*dcache_pkg::WORD_BITS
                                       +: dcache_pkg::WORD_BITS] <= request.data;
        end
    end

    // one MSHR per block means a block is never filled twice
    assert property (@(posedge clock) disable iff (reset) $onehot0(way_hit));

endmodule

/* dcache.f */
dcache_pkg.sv
miss_queue.sv
mshr_file.sv
cache_array.sv
writeback_buffer.sv
dcache.sv
tb_memory.sv
tb_dcache.sv

/* dcache.sv */
module dcache (
    input  logic                                                clock,
    input  logic                                                reset,
    input  dcache_pkg::cache_req_t                              request,
    output logic                                                accept,
    output dcache_pkg::load_resp_t                              hit_resp,
    output dcache_pkg::load_resp_t [dcache_pkg::QUEUE_DEPTH-1:0] fill_resp,
    output dcache_pkg::mem_req_t                                mem_req,
    input  dcache_pkg::mem_tag_t                                mem_transaction_tag,
    input  dcache_pkg::mem_tag_t                                mem_data_tag,
    input  dcache_pkg::block_t                                  mem_data
);

    logic                 hit;
    logic                 hit_accept;
    logic                 miss_accept;
    logic                 mshr_grant;
    dcache_pkg::victim_t  victim;
    dcache_pkg::fill_t    fill;
    dcache_pkg::mem_req_t load_req;

    cache_array array (
        .clock      (clock),
        .reset      (reset),
        .request    (request),
        .fill       (fill),
        .hit        (hit),
        .hit_accept (hit_accept),
        .hit_resp   (hit_resp),
        .fill_resp  (fill_resp),
        .victim     (victim)
    );

    mshr_file mshrs (
        .clock               (clock),
        .reset               (reset),
        .request             (request),
        .hit                 (hit),
        .mshr_grant          (mshr_grant),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data),
        .miss_accept         (miss_accept),
        .load_req            (load_req),
        .fill                (fill)
    );

    // victims go out ahead of MSHR loads
    writeback_buffer wb (
        .clock      (clock),
        .reset      (reset),
        .victim     (victim),
        .load_req   (load_req),
        .mem_req    (mem_req),
        .mshr_grant (mshr_grant)
    );

    assign accept = hit_accept | miss_accept;

endmodule

/* dcache_cases.txt */
// op (0 load, 1 store), byte address, store data, load id, expected load value; all hex
// words never stored read back as address ^ 5a5a0000
0 00000100 00000000 0 5a5a0100
1 00000104 cafe0001 0 00000000
0 00000104 00000000 1 cafe0001
1 00000100 11110000 0 00000000
0 00000100 00000000 2 11110000
0 00000208 00000000 3 5a5a0208
0 0000020c 00000000 4 5a5a020c
0 00000310 00000000 5 5a5a0310
1 00000314 beef0314 0 00000000
0 00000314 00000000 6 beef0314
1 00000418 0badf00d 0 00000000
0 00000418 00000000 7 0badf00d
1 00000120 d1d10120 0 00000000
1 00000144 d2d20144 0 00000000
0 00000100 00000000 0 11110000
0 00000104 00000000 1 cafe0001
0 00000120 00000000 2 d1d10120
0 00000144 00000000 3 d2d20144
0 00000140 00000000 4 5a5a0140
0 00000500 00000000 5 5a5a0500
0 00000608 00000000 6 5a5a0608
0 00000710 00000000 7 5a5a0710
1 0000060c 600d060c 0 00000000
0 0000060c 00000000 0 600d060c
0 00000504 00000000 1 5a5a0504
0 00000714 00000000 2 5a5a0714
1 00000100 22220100 0 00000000
0 00000100 00000000 3 22220100

/* dcache_pkg.sv */
package dcache_pkg;

    // geometry: 2 ways x 4 sets of two-word blocks
    localparam int WORD_BITS    = 32;
    localparam int OFFSET_BITS  = 3;
    localparam int SETS         = 4;
    localparam int INDEX_BITS   = 2;
    localparam int TAG_BITS     = 27;
    localparam int WAYS         = 2;
    localparam int WAY_BITS     = 1;

    localparam int MSHRS        = 2;
    // power of two, so queue pointers wrap on their own
    localparam int QUEUE_DEPTH  = 2;
    localparam int QUEUE_PTR_BITS = 1;
    localparam int QUEUE_CNT_BITS = 2;

    localparam int MEM_TAG_BITS = 4;
    localparam int ID_BITS      = 3;

    typedef logic [31:0]               addr_t;
    typedef logic [WORD_BITS-1:0]      word_t;
    typedef logic [2*WORD_BITS-1:0]    block_t;
    typedef logic [TAG_BITS-1:0]       tag_t;
    typedef logic [INDEX_BITS-1:0]     index_t;
    typedef logic [WAY_BITS-1:0]       way_t;
    typedef logic [MEM_TAG_BITS-1:0]   mem_tag_t;
    typedef logic [ID_BITS-1:0]        load_id_t;
    typedef logic [QUEUE_PTR_BITS-1:0] queue_ptr_t;
    typedef logic [QUEUE_CNT_BITS-1:0] queue_count_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_command_t;

    typedef enum logic [1:0] {
        MSHR_INVALID,
        MSHR_PENDING,
        MSHR_WAIT_DATA
    } mshr_state_t;

    typedef struct packed {
        logic     valid;
        logic     is_store;
        addr_t    addr;
        word_t    data;
        load_id_t id;
    } cache_req_t;

    typedef struct packed {
        logic     is_store;
        logic     word_sel;
        word_t    data;
        load_id_t id;
    } queue_entry_t;

    typedef struct packed {
        logic                             valid;
        tag_t                             tag;
        index_t                           index;
        block_t                           block;
        queue_entry_t [QUEUE_DEPTH-1:0]   entries;
        logic         [QUEUE_DEPTH-1:0]   entry_valid;
    } fill_t;

    typedef struct packed {
        logic     valid;
        load_id_t id;
        word_t    data;
    } load_resp_t;

    typedef struct packed {
        logic   valid;
        addr_t  addr;
        block_t block;
    } victim_t;

    typedef struct packed {
        mem_command_t command;
        addr_t        addr;
        block_t       data;
    } mem_req_t;

    typedef struct packed {
        mshr_state_t state;
        tag_t        tag;
        index_t      index;
        mem_tag_t    mem_tag;
    } mshr_entry_t;

endpackage

/* miss_queue.sv */
module miss_queue (
    input  logic                                                  clock,
    input  logic                                                  reset,
    input  logic                                                  push,
    input  dcache_pkg::queue_entry_t                              push_entry,
    input  logic                                                  flush,
    output logic                                                  full,
    output dcache_pkg::queue_entry_t [dcache_pkg::QUEUE_DEPTH-1:0] entries,
    output logic [dcache_pkg::QUEUE_DEPTH-1:0]                    entry_valid
);

    dcache_pkg::queue_entry_t [dcache_pkg::QUEUE_DEPTH-1:0] slots;
    dcache_pkg::queue_ptr_t   head;
    dcache_pkg::queue_ptr_t   tail;
    dcache_pkg::queue_count_t count;

    assign full = count == dcache_pkg::queue_count_t'(dcache_pkg::QUEUE_DEPTH);

    // oldest entry first
    always_comb begin
        for (int i = 0; i < dcache_pkg::QUEUE_DEPTH; i++) begin
            entries[i]     = slots[head + dcache_pkg::queue_ptr_t'(i)];
            entry_valid[i] = dcache_pkg::queue_count_t'(i) < count;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            // drop everything, pointers stay put
            head  <= tail;
            count <= '0;
        end else if (push && !full) begin
            tail  <= tail + 1'b1;
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (push && !full) begin
            slots[tail] <= push_entry;
        end
    end

    // mshr_file checks room before merging
    assert property (@(posedge clock) disable iff (reset) !(push && full));

endmodule

/* mshr_file.sv */
module mshr_file (
    input  logic                   clock,
    input  logic                   reset,
    input  dcache_pkg::cache_req_t request,
    input  logic                   hit,
    input  logic                   mshr_grant,
    input  dcache_pkg::mem_tag_t   mem_transaction_tag,
    input  dcache_pkg::mem_tag_t   mem_data_tag,
    input  dcache_pkg::block_t     mem_data,
    output logic                   miss_accept,
    output dcache_pkg::mem_req_t   load_req,
    output dcache_pkg::fill_t      fill
);

    dcache_pkg::mshr_entry_t [dcache_pkg::MSHRS-1:0] mshrs;
    dcache_pkg::mshr_entry_t [dcache_pkg::MSHRS-1:0] next_mshrs;

    dcache_pkg::queue_entry_t [dcache_pkg::MSHRS-1:0][dcache_pkg::QUEUE_DEPTH-1:0] q_entries;
    logic [dcache_pkg::MSHRS-1:0][dcache_pkg::QUEUE_DEPTH-1:0] q_valid;
    logic [dcache_pkg::MSHRS-1:0] q_full;
    logic [dcache_pkg::MSHRS-1:0] push;
    logic [dcache_pkg::MSHRS-1:0] match;
    logic [dcache_pkg::MSHRS-1:0] fill_hit;

    dcache_pkg::tag_t         req_tag;
    dcache_pkg::index_t       req_index;
    dcache_pkg::queue_entry_t push_entry;

    assign req_tag   = request.addr[31 -: dcache_pkg::TAG_BITS];
    assign req_index = request.addr[dcache_pkg::OFFSET_BITS +: dcache_pkg::INDEX_BITS];

    assign push_entry = '{
        is_store: request.is_store,
        word_sel: request.addr[dcache_pkg::OFFSET_BITS-1],
        data:     request.data,
        id:       request.id
    };

    for (genvar j = 0; j < dcache_pkg::MSHRS; j++) begin : g_queue
        miss_queue queue (
            .clock       (clock),
            .reset       (reset),
            .push        (push[j]),
            .push_entry  (push_entry),
            .flush       (fill_hit[j]),
            .full        (q_full[j]),
            .entries     (q_entries[j]),
            .entry_valid (q_valid[j])
        );
    end

    always_comb begin
        for (int j = 0; j < dcache_pkg::MSHRS; j++) begin
            match[j] = mshrs[j].state != dcache_pkg::MSHR_INVALID
                    && mshrs[j].tag == req_tag && mshrs[j].index == req_index;
            fill_hit[j] = mshrs[j].state == dcache_pkg::MSHR_WAIT_DATA
                       && mem_data_tag != '0 && mshrs[j].mem_tag == mem_data_tag;
        end
    end

    always_comb begin
        next_mshrs  = mshrs;
        push        = '0;
        miss_accept = 1'b0;
        load_req    = '0;
        fill        = '0;

        // a block being refilled this cycle takes no new requests
        if (request.valid && !hit && !(|(match & fill_hit))) begin
            if (|match) begin
                for (int j = 0; j < dcache_pkg::MSHRS; j++) begin
                    if (match[j] && !q_full[j]) begin
                        push[j]     = 1'b1;
                        miss_accept = 1'b1;
                    end
                end
            end else begin
                for (int j = 0; j < dcache_pkg::MSHRS; j++) begin
                    if (mshrs[j].state == dcache_pkg::MSHR_INVALID && !miss_accept) begin
                        push[j]       = 1'b1;
                        miss_accept   = 1'b1;
                        next_mshrs[j] = '{
                            state:   dcache_pkg::MSHR_PENDING,
                            tag:     req_tag,
                            index:   req_index,
                            mem_tag: '0
                        };
                    end
                end
            end
        end

        // lowest pending entry asks for the port
        for (int j = 0; j < dcache_pkg::MSHRS; j++) begin
            if (mshrs[j].state == dcache_pkg::MSHR_PENDING
                && load_req.command == dcache_pkg::MEM_NONE) begin
                load_req.command = dcache_pkg::MEM_LOAD;
                load_req.addr    = {mshrs[j].tag, mshrs[j].index,
                                    {dcache_pkg::OFFSET_BITS{1'b0}}};
                if (mshr_grant && mem_transaction_tag != '0) begin
                    next_mshrs[j].state   = dcache_pkg::MSHR_WAIT_DATA;
                    next_mshrs[j].mem_tag = mem_transaction_tag;
                end
            end
        end

        for (int j = 0; j < dcache_pkg::MSHRS; j++) begin
            if (fill_hit[j]) begin
                fill.valid          = 1'b1;
                fill.tag            = mshrs[j].tag;
                fill.index          = mshrs[j].index;
                fill.block          = mem_data;
                fill.entries        = q_entries[j];
                fill.entry_valid    = q_valid[j];
                next_mshrs[j].state = dcache_pkg::MSHR_INVALID;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int j = 0; j < dcache_pkg::MSHRS; j++) begin
                mshrs[j].state <= dcache_pkg::MSHR_INVALID;
            end
        end else begin
            mshrs <= next_mshrs;
        end
    end

    // memory never has two live transactions with one tag
    assert property (@(posedge clock) disable iff (reset) $onehot0(fill_hit));

endmodule

/* tb_dcache.sv */
module tb_dcache;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLOCK_PERIOD   = 8;
    localparam int NUM_CASES      = 28;
    localparam int CASE_FIELDS    = 5;
    localparam int TIMEOUT_CYCLES = NUM_CASES * 20;
    localparam int SEED           = 32'h3821;
    localparam int IDS            = 1 << dcache_pkg::ID_BITS;

    typedef struct packed {
        logic                 is_store;
        dcache_pkg::addr_t    addr;
        dcache_pkg::word_t    data;
        dcache_pkg::load_id_t id;
        dcache_pkg::word_t    expected;
    } test_case_t;

    logic                                                 clock;
    logic                                                 reset;
    dcache_pkg::cache_req_t                               request;
    logic                                                 accept;
    dcache_pkg::load_resp_t                               hit_resp;
    dcache_pkg::load_resp_t [dcache_pkg::QUEUE_DEPTH-1:0] fill_resp;
    dcache_pkg::mem_req_t                                 mem_req;
    dcache_pkg::mem_tag_t                                 mem_transaction_tag;
    dcache_pkg::mem_tag_t                                 mem_data_tag;
    dcache_pkg::block_t                                   mem_data;

    dcache_pkg::word_t case_words [NUM_CASES*CASE_FIELDS];
    test_case_t        cases [NUM_CASES];
    logic [IDS-1:0]    pending;
    int                case_of_id [IDS];
    int                pass_count;
    int                fail_count;
    int                error_count;
    int                cycle_count;

    dcache DUT (
        .clock               (clock),
        .reset               (reset),
        .request             (request),
        .accept              (accept),
        .hit_resp            (hit_resp),
        .fill_resp           (fill_resp),
        .mem_req             (mem_req),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data)
    );

    tb_memory memory (
        .clock               (clock),
        .reset               (reset),
        .mem_req             (mem_req),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    task automatic resolve_load(input dcache_pkg::load_resp_t resp);
        int c;
        if (!pending[resp.id]) begin
            $display("unexpected load response for id %0d with data %h", resp.id, resp.data);
            error_count++;
        end else begin
            c = case_of_id[resp.id];
            pending[resp.id] = 1'b0;
            if (resp.data !== cases[c].expected) begin
                $display("FAIL case %0d load %h id %0d: expected %h, actual %h",
                         c, cases[c].addr, resp.id, cases[c].expected, resp.data);
                fail_count++;
            end else begin
                $display("ok   case %0d load %h id %0d: %h", c, cases[c].addr, resp.id, resp.data);
                pass_count++;
            end
        end
    endtask

    // hold the request until the cache takes it
    task automatic issue_case(input int c);
        int gap;
        gap = $urandom % 3;
        repeat (gap) begin
            @(posedge clock);
            #1;
        end
        if (!cases[c].is_store) begin
            while (pending[cases[c].id]) begin
                @(posedge clock);
                #1;
            end
            pending[cases[c].id]    = 1'b1;
            case_of_id[cases[c].id] = c;
        end
        request = '{
            valid:    1'b1,
            is_store: cases[c].is_store,
            addr:     cases[c].addr,
            data:     cases[c].data,
            id:       cases[c].id
        };
        @(negedge clock);
        while (!accept) begin
            @(negedge clock);
        end
        @(posedge clock);
        #1;
        request.valid = 1'b0;
        if (cases[c].is_store) begin
            $display("ok   case %0d store %h <- %h", c, cases[c].addr, cases[c].data);
            pass_count++;
        end
    endtask

    task automatic report_unresolved();
        if (pending == '0) begin
            $display("no load outstanding, a request was never accepted");
        end
        for (int i = 0; i < IDS; i++) begin
            if (pending[i]) begin
                $display("  load id %0d from case %0d, address %h",
                         i, case_of_id[i], cases[case_of_id[i]].addr);
            end
        end
    endtask

    // responses are settled by the falling edge
    always @(negedge clock) begin
        if (!reset) begin
            if (hit_resp.valid) begin
                resolve_load(hit_resp);
            end
            for (int i = 0; i < dcache_pkg::QUEUE_DEPTH; i++) begin
                if (fill_resp[i].valid) begin
                    resolve_load(fill_resp[i]);
                end
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout after %0d cycles, loads still unresolved:", cycle_count);
        report_unresolved();
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        reset       = 1'b1;
        request     = '0;
        pending     = '0;
        pass_count  = 0;
        fail_count  = 0;
        error_count = 0;
        $readmemh("dcache_cases.txt", case_words);
        for (int c = 0; c < NUM_CASES; c++) begin
            cases[c] = '{
                is_store: case_words[c*CASE_FIELDS][0],
                addr:     case_words[c*CASE_FIELDS+1],
                data:     case_words[c*CASE_FIELDS+2],
                id:       case_words[c*CASE_FIELDS+3][dcache_pkg::ID_BITS-1:0],
                expected: case_words[c*CASE_FIELDS+4]
            };
        end
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        for (int c = 0; c < NUM_CASES; c++) begin
            issue_case(c);
        end
        // drain outstanding misses
        while (pending != '0) begin
            @(negedge clock);
        end

        $display("cases: %0d passed, %0d failed, %0d other errors",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* tb_memory.sv */
module tb_memory (
    input  logic                 clock,
    input  logic                 reset,
    input  dcache_pkg::mem_req_t mem_req,
    output dcache_pkg::mem_tag_t mem_transaction_tag,
    output dcache_pkg::mem_tag_t mem_data_tag,
    output dcache_pkg::block_t   mem_data
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LATENCY = 3;

    typedef struct packed {
        dcache_pkg::mem_tag_t tag;
        dcache_pkg::block_t   block;
    } mem_return_t;

    // only written words live here
    dcache_pkg::word_t    words [dcache_pkg::addr_t];
    mem_return_t [LATENCY-1:0] pipe;
    dcache_pkg::mem_tag_t next_tag;

    function automatic dcache_pkg::word_t read_word(input dcache_pkg::addr_t addr);
        if (words.exists(addr)) begin
            return words[addr];
        end
        return addr ^ 32'h5a5a0000;
    endfunction

    // a load is taken in the cycle it is offered
    assign mem_transaction_tag = mem_req.command == dcache_pkg::MEM_LOAD ? next_tag : '0;
    assign mem_data_tag        = pipe[LATENCY-1].tag;
    assign mem_data            = pipe[LATENCY-1].block;

    always @(posedge clock) begin
        if (reset) begin
            pipe     <= '0;
            next_tag <= dcache_pkg::mem_tag_t'(1);
        end else begin
            for (int i = LATENCY - 1; i > 0; i--) begin
                pipe[i] <= pipe[i-1];
            end
            pipe[0] <= '0;
            case (mem_req.command)
                dcache_pkg::MEM_LOAD: begin
                    pipe[0] <= '{
                        tag:   next_tag,
                        block: {read_word(mem_req.addr + 32'd4), read_word(mem_req.addr)}
                    };
                    // tags rotate over 1..15, zero means idle
                    next_tag <= next_tag == '1 ? dcache_pkg::mem_tag_t'(1) : next_tag + 1'b1;
                end
                dcache_pkg::MEM_STORE: begin
                    words[mem_req.addr]         = mem_req.data[31:0];
                    words[mem_req.addr + 32'd4] = mem_req.data[63:32];
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* writeback_buffer.sv */
module writeback_buffer (
    input  logic                 clock,
    input  logic                 reset,
    input  dcache_pkg::victim_t  victim,
    input  dcache_pkg::mem_req_t load_req,
    output dcache_pkg::mem_req_t mem_req,
    output logic                 mshr_grant
);

    dcache_pkg::victim_t held;

    // stores are always taken, so a victim stays for one cycle only
    always_ff @(posedge clock) begin
        if (reset) begin
            held.valid <= 1'b0;
        end else begin
            held <= victim;
        end
    end

    always_comb begin
        if (held.valid) begin
            mem_req    = '{
                command: dcache_pkg::MEM_STORE,
                addr:    held.addr,
                data:    held.block
            };
            mshr_grant = 1'b0;
        end else begin
            mem_req    = load_req;
            mshr_grant = load_req.command == dcache_pkg::MEM_LOAD;
        end
    end

    // one victim in flight at a time
    assert property (@(posedge clock) disable iff (reset)
        !(held.valid && victim.valid));

endmodule
